//--- include/lc4_core_config.svh
`ifndef LC4_CORE_CONFIG_SVH
`define LC4_CORE_CONFIG_SVH

// first fetch address after reset
`define LC4_RESET_PC     16'h8200

// architectural register count
`define LC4_NUM_REGS     8

// opcodes in insn[15:12]
`define LC4_OP_BR        4'b0000
`define LC4_OP_ADD       4'b0001
`define LC4_OP_LDR       4'b0110
`define LC4_OP_STR       4'b0111
`define LC4_OP_CONST     4'b1001

// BR with an empty nzp field
`define LC4_NOP          16'h0000

// commit stall codes
`define LC4_STALL_NONE   2'd0
`define LC4_STALL_FLUSH  2'd2
`define LC4_STALL_LOAD   2'd3

`endif

//--- lc4_core.f
+incdir+include
rtl/lc4_pkg.sv
rtl/lc4_decoder.sv
rtl/lc4_alu.sv
rtl/lc4_regfile.sv
rtl/lc4_pc_unit.sv
rtl/lc4_hazard_unit.sv
rtl/lc4_bypass.sv
rtl/lc4_core.sv
sim/lc4_core_sva.sv
sim/lc4_core_tb.sv

//--- rtl/lc4_alu.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_core_config.svh"

module lc4_alu import lc4_pkg::*; (
    input  word_t i_insn,
    input  word_t i_pc,
    input  word_t i_rs_data,
    input  word_t i_rt_data,
    output word_t o_result
);

    word_t imm5_sx;
    word_t imm6_sx;
    word_t imm9_sx;

    assign imm5_sx = {{11{i_insn[4]}}, i_insn[4:0]};
    assign imm6_sx = {{10{i_insn[5]}}, i_insn[5:0]};
    assign imm9_sx = {{7{i_insn[8]}}, i_insn[8:0]};

    // i_pc already holds the incremented pc of the instruction
    always_comb begin
        case (i_insn[15:12])
            `LC4_OP_ADD:   o_result = i_insn[5] ? (i_rs_data + imm5_sx)
                                                : (i_rs_data + i_rt_data);
            `LC4_OP_CONST: o_result = imm9_sx;
            `LC4_OP_LDR,
            `LC4_OP_STR:   o_result = i_rs_data + imm6_sx;
            `LC4_OP_BR:    o_result = i_pc + imm9_sx;
            default:       o_result = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/lc4_bypass.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_bypass import lc4_pkg::*; (
    input  reg_sel_t i_x_rs_sel,
    input  reg_sel_t i_x_rt_sel,
    input  word_t    i_x_rs_reg,
    input  word_t    i_x_rt_reg,
    input  reg_sel_t i_m_rd_sel,
    input  logic     i_m_rd_we,
    input  logic     i_m_is_load,
    input  word_t    i_m_result,
    input  word_t    i_m_load_data,
    input  reg_sel_t i_w_rd_sel,
    input  logic     i_w_rd_we,
    input  word_t    i_w_data,
    input  reg_sel_t i_m_rt_sel,
    input  word_t    i_m_store_reg,
    input  nzp_t     i_nzp_reg,
    output word_t    o_rs_fwd,
    output word_t    o_rt_fwd,
    output word_t    o_store_fwd,
    output nzp_t     o_nzp_fwd
);

    logic m_alu_valid;
    logic rs_from_m;
    logic rt_from_m;
    logic rs_from_w;
    logic rt_from_w;
    nzp_t load_nzp;

    // a load in memory has no result yet, the stall or WM path covers it
    assign m_alu_valid = i_m_rd_we && !i_m_is_load;

    assign rs_from_m = m_alu_valid && (i_m_rd_sel == i_x_rs_sel);
    assign rt_from_m = m_alu_valid && (i_m_rd_sel == i_x_rt_sel);
    assign rs_from_w = i_w_rd_we && (i_w_rd_sel == i_x_rs_sel);
    assign rt_from_w = i_w_rd_we && (i_w_rd_sel == i_x_rt_sel);

    // MX ahead of WX, the younger producer wins
    assign o_rs_fwd = rs_from_m ? i_m_result : (rs_from_w ? i_w_data : i_x_rs_reg);
    assign o_rt_fwd = rt_from_m ? i_m_result : (rt_from_w ? i_w_data : i_x_rt_reg);

    // WM for store data
    assign o_store_fwd = (i_w_rd_we && (i_w_rd_sel == i_m_rt_sel)) ? i_w_data
                                                                   : i_m_store_reg;

    assign load_nzp = i_m_load_data[15]          ? 3'b100 :
                      (i_m_load_data == 16'h0000) ? 3'b010 : 3'b001;

    assign o_nzp_fwd = i_m_is_load ? load_nzp : i_nzp_reg;

endmodule

`default_nettype wire

//--- rtl/lc4_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_core_config.svh"

module lc4_core import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_reset,
    output word_t    o_cur_pc,
    input  word_t    i_cur_insn,
    output word_t    o_dmem_addr,
    output logic     o_dmem_we,
    output word_t    o_dmem_towrite,
    input  word_t    i_cur_dmem_data,
    output stall_t   o_test_stall,
    output word_t    o_test_pc,
    output word_t    o_test_insn,
    output logic     o_test_regfile_we,
    output reg_sel_t o_test_regfile_wsel,
    output word_t    o_test_regfile_data,
    output logic     o_test_nzp_we,
    output nzp_t     o_test_nzp_bits,
    output logic     o_test_dmem_we,
    output word_t    o_test_dmem_addr,
    output word_t    o_test_dmem_data
);

    // stage pcs carry pc+1, which is also the branch base
    word_t    pc_plus_one;
    word_t    d_insn, d_pc_inc;
    stall_t   d_stall;
    reg_sel_t dec_rs_sel, dec_rt_sel, dec_rd_sel;
    logic     dec_rs_re, dec_rt_re, dec_rd_we, dec_nzp_we;
    logic     dec_is_load, dec_is_store, dec_is_branch;
    word_t    rf_rs_data, rf_rt_data;
    logic     load_stall, branch_taken, x_bubble;
    stall_t   hz_stall_code;

    word_t    x_insn, x_pc_inc, x_rs_reg, x_rt_reg, x_alu_result;
    stall_t   x_stall;
    reg_sel_t x_rs_sel, x_rt_sel, x_rd_sel;
    logic     x_rd_we, x_nzp_we, x_is_load, x_is_store, x_is_branch;
    word_t    rs_fwd, rt_fwd, store_fwd;
    nzp_t     nzp_fwd, nzp_reg, x_alu_nzp;

    word_t    m_insn, m_pc_inc, m_result, m_store_reg, m_dmem_data;
    stall_t   m_stall;
    reg_sel_t m_rt_sel, m_rd_sel;
    logic     m_rd_we, m_nzp_we, m_is_load, m_is_store;
    nzp_t     m_nzp;

    word_t    w_insn, w_pc_inc, w_result, w_dmem_addr, w_dmem_data, w_data;
    stall_t   w_stall;
    reg_sel_t w_rd_sel;
    logic     w_rd_we, w_nzp_we, w_is_load, w_is_store;
    nzp_t     w_nzp;

    lc4_pc_unit u_pc_unit (
        .gwe(gwe), .i_reset(i_reset), .i_hold(load_stall), .i_redirect(branch_taken),
        .i_target(x_alu_result), .o_pc(o_cur_pc), .o_pc_plus_one(pc_plus_one)
    );

    // decode register holds during a load stall, takes a nop on a flush
    always_ff @(posedge gwe) begin
        if (i_reset || branch_taken) begin
            d_insn  <= `LC4_NOP;
            d_stall <= `LC4_STALL_FLUSH;
        end else if (!load_stall) begin
            d_insn  <= i_cur_insn;
            d_stall <= `LC4_STALL_NONE;
        end
    end

    always_ff @(posedge gwe) begin
        if (!load_stall) begin
            d_pc_inc <= pc_plus_one;
        end
    end

    lc4_decoder u_decoder (
        .i_insn(d_insn), .o_rs_sel(dec_rs_sel), .o_rt_sel(dec_rt_sel), .o_rd_sel(dec_rd_sel),
        .o_rs_re(dec_rs_re), .o_rt_re(dec_rt_re), .o_rd_we(dec_rd_we), .o_nzp_we(dec_nzp_we),
        .o_is_load(dec_is_load), .o_is_store(dec_is_store), .o_is_branch(dec_is_branch)
    );

    lc4_regfile u_regfile (
        .gwe(gwe), .i_reset(i_reset), .i_rs_sel(dec_rs_sel), .i_rt_sel(dec_rt_sel),
        .i_rd_sel(w_rd_sel), .i_rd_we(w_rd_we), .i_wdata(w_data),
        .o_rs_data(rf_rs_data), .o_rt_data(rf_rt_data)
    );

    lc4_hazard_unit u_hazard (
        .i_d_rs_sel(dec_rs_sel), .i_d_rt_sel(dec_rt_sel), .i_d_rs_re(dec_rs_re),
        .i_d_rt_re(dec_rt_re), .i_d_is_store(dec_is_store), .i_d_is_branch(dec_is_branch),
        .i_x_rd_sel(x_rd_sel), .i_x_is_load(x_is_load), .i_x_is_branch(x_is_branch),
        .i_x_nzp_field(x_insn[11:9]), .i_nzp_fwd(nzp_fwd), .o_load_stall(load_stall),
        .o_branch_taken(branch_taken), .o_d_stall_code(hz_stall_code)
    );

    assign x_bubble = load_stall || branch_taken;

    always_ff @(posedge gwe) begin
        if (i_reset || x_bubble) begin
            x_insn      <= `LC4_NOP;
            x_stall     <= i_reset ? `LC4_STALL_FLUSH : hz_stall_code;
            x_rd_we     <= 1'b0;
            x_nzp_we    <= 1'b0;
            x_is_load   <= 1'b0;
            x_is_store  <= 1'b0;
            x_is_branch <= 1'b0;
        end else begin
            x_insn      <= d_insn;
            x_stall     <= d_stall;
            x_rd_we     <= dec_rd_we;
            x_nzp_we    <= dec_nzp_we;
            x_is_load   <= dec_is_load;
            x_is_store  <= dec_is_store;
            x_is_branch <= dec_is_branch;
        end
    end

    always_ff @(posedge gwe) begin
        x_pc_inc <= d_pc_inc;
        x_rs_sel <= dec_rs_sel;
        x_rt_sel <= dec_rt_sel;
        x_rd_sel <= dec_rd_sel;
        x_rs_reg <= rf_rs_data;
        x_rt_reg <= rf_rt_data;
    end

    lc4_bypass u_bypass (
        .i_x_rs_sel(x_rs_sel), .i_x_rt_sel(x_rt_sel), .i_x_rs_reg(x_rs_reg),
        .i_x_rt_reg(x_rt_reg), .i_m_rd_sel(m_rd_sel), .i_m_rd_we(m_rd_we),
        .i_m_is_load(m_is_load), .i_m_result(m_result), .i_m_load_data(i_cur_dmem_data),
        .i_w_rd_sel(w_rd_sel), .i_w_rd_we(w_rd_we), .i_w_data(w_data),
        .i_m_rt_sel(m_rt_sel), .i_m_store_reg(m_store_reg), .i_nzp_reg(nzp_reg),
        .o_rs_fwd(rs_fwd), .o_rt_fwd(rt_fwd), .o_store_fwd(store_fwd), .o_nzp_fwd(nzp_fwd)
    );

    lc4_alu u_alu (
        .i_insn(x_insn), .i_pc(x_pc_inc), .i_rs_data(rs_fwd), .i_rt_data(rt_fwd),
        .o_result(x_alu_result)
    );

    assign x_alu_nzp = x_alu_result[15]          ? 3'b100 :
                       (x_alu_result == 16'h0000) ? 3'b010 : 3'b001;

    // the younger ADD or CONST in execute overrides a load leaving memory
    always_ff @(posedge gwe) begin
        if (i_reset) begin
            nzp_reg <= 3'b010;
        end else if (x_nzp_we && !x_is_load) begin
            nzp_reg <= x_alu_nzp;
        end else if (m_is_load) begin
            nzp_reg <= nzp_fwd;
        end
    end

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            m_insn     <= `LC4_NOP;
            m_stall    <= `LC4_STALL_FLUSH;
            m_rd_we    <= 1'b0;
            m_nzp_we   <= 1'b0;
            m_is_load  <= 1'b0;
            m_is_store <= 1'b0;
        end else begin
            m_insn     <= x_insn;
            m_stall    <= x_stall;
            m_rd_we    <= x_rd_we;
            m_nzp_we   <= x_nzp_we;
            m_is_load  <= x_is_load;
            m_is_store <= x_is_store;
        end
    end

    always_ff @(posedge gwe) begin
        m_pc_inc    <= x_pc_inc;
        m_rt_sel    <= x_rt_sel;
        m_rd_sel    <= x_rd_sel;
        m_result    <= x_alu_result;
        m_store_reg <= rt_fwd;
        m_nzp       <= x_alu_nzp;
    end

    // data memory port
    assign o_dmem_addr    = (m_is_load || m_is_store) ? m_result : 16'h0000;
    assign o_dmem_we      = m_is_store;
    assign o_dmem_towrite = m_is_store ? store_fwd : 16'h0000;
    assign m_dmem_data    = m_is_load ? i_cur_dmem_data : o_dmem_towrite;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            w_insn     <= `LC4_NOP;
            w_stall    <= `LC4_STALL_FLUSH;
            w_rd_we    <= 1'b0;
            w_nzp_we   <= 1'b0;
            w_is_load  <= 1'b0;
            w_is_store <= 1'b0;
        end else begin
            w_insn     <= m_insn;
            w_stall    <= m_stall;
            w_rd_we    <= m_rd_we;
            w_nzp_we   <= m_nzp_we;
            w_is_load  <= m_is_load;
            w_is_store <= m_is_store;
        end
    end

    // load nzp comes from the forwarded value while the load sits in memory
    always_ff @(posedge gwe) begin
        w_pc_inc    <= m_pc_inc;
        w_rd_sel    <= m_rd_sel;
        w_result    <= m_result;
        w_nzp       <= m_is_load ? nzp_fwd : m_nzp;
        w_dmem_addr <= o_dmem_addr;
        w_dmem_data <= m_dmem_data;
    end

    assign w_data = w_is_load ? w_dmem_data : w_result;

    // commit record
    assign o_test_stall        = w_stall;
    assign o_test_pc           = w_pc_inc - 16'd1;
    assign o_test_insn         = w_insn;
    assign o_test_regfile_we   = w_rd_we;
    assign o_test_regfile_wsel = w_rd_sel;
    assign o_test_regfile_data = w_data;
    assign o_test_nzp_we       = w_nzp_we;
    assign o_test_nzp_bits     = w_nzp;
    assign o_test_dmem_we      = w_is_store;
    assign o_test_dmem_addr    = w_dmem_addr;
    assign o_test_dmem_data    = w_dmem_data;

endmodule

`default_nettype wire

//--- rtl/lc4_decoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_core_config.svh"

module lc4_decoder import lc4_pkg::*; (
    input  word_t    i_insn,
    output reg_sel_t o_rs_sel,
    output reg_sel_t o_rt_sel,
    output reg_sel_t o_rd_sel,
    output logic     o_rs_re,
    output logic     o_rt_re,
    output logic     o_rd_we,
    output logic     o_nzp_we,
    output logic     o_is_load,
    output logic     o_is_store,
    output logic     o_is_branch
);

    always_comb begin
        // field positions shared by most formats
        o_rs_sel    = i_insn[8:6];
        o_rt_sel    = i_insn[2:0];
        o_rd_sel    = i_insn[11:9];
        o_rs_re     = 1'b0;
        o_rt_re     = 1'b0;
        o_rd_we     = 1'b0;
        o_nzp_we    = 1'b0;
        o_is_load   = 1'b0;
        o_is_store  = 1'b0;
        o_is_branch = 1'b0;

        case (i_insn[15:12])
            `LC4_OP_BR: begin
                // an empty nzp field never branches, that is the nop
                o_is_branch = (i_insn[11:9] != 3'b000);
            end
            `LC4_OP_ADD: begin
                // register form only with sub-op 000, imm5 form when bit 5 set
                if (i_insn[5] || (i_insn[5:3] == 3'b000)) begin
                    o_rs_re  = 1'b1;
                    o_rt_re  = ~i_insn[5];
                    o_rd_we  = 1'b1;
                    o_nzp_we = 1'b1;
                end
            end
            `LC4_OP_LDR: begin
                o_rs_re   = 1'b1;
                o_rd_we   = 1'b1;
                o_nzp_we  = 1'b1;
                o_is_load = 1'b1;
            end
            `LC4_OP_STR: begin
                // store data register sits where rd would be
                o_rt_sel   = i_insn[11:9];
                o_rs_re    = 1'b1;
                o_rt_re    = 1'b1;
                o_is_store = 1'b1;
            end
            `LC4_OP_CONST: begin
                o_rd_we  = 1'b1;
                o_nzp_we = 1'b1;
            end
            default: begin
                o_rs_re = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/lc4_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_core_config.svh"

module lc4_hazard_unit import lc4_pkg::*; (
    input  reg_sel_t i_d_rs_sel,
    input  reg_sel_t i_d_rt_sel,
    input  logic     i_d_rs_re,
    input  logic     i_d_rt_re,
    input  logic     i_d_is_store,
    input  logic     i_d_is_branch,
    input  reg_sel_t i_x_rd_sel,
    input  logic     i_x_is_load,
    input  logic     i_x_is_branch,
    input  nzp_t     i_x_nzp_field,
    input  nzp_t     i_nzp_fwd,
    output logic     o_load_stall,
    output logic     o_branch_taken,
    output stall_t   o_d_stall_code
);

    logic rs_hit;
    logic rt_hit;

    assign rs_hit = i_d_rs_re && (i_d_rs_sel == i_x_rd_sel);

    // store data gets the load value later through the WM path
    assign rt_hit = i_d_rt_re && !i_d_is_store && (i_d_rt_sel == i_x_rd_sel);

    // a branch needs the nzp of the load, which is known one stage too late
    assign o_load_stall = i_x_is_load && (rs_hit || rt_hit || i_d_is_branch);

    assign o_branch_taken = i_x_is_branch && ((i_x_nzp_field & i_nzp_fwd) != 3'b000);

    always_comb begin
        if (o_branch_taken) begin
            o_d_stall_code = `LC4_STALL_FLUSH;
        end else if (o_load_stall) begin
            o_d_stall_code = `LC4_STALL_LOAD;
        end else begin
            o_d_stall_code = `LC4_STALL_NONE;
        end
    end

endmodule

`default_nettype wire

//--- rtl/lc4_pc_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_core_config.svh"

module lc4_pc_unit import lc4_pkg::*; (
    input  logic  gwe,
    input  logic  i_reset,
    input  logic  i_hold,
    input  logic  i_redirect,
    input  word_t i_target,
    output word_t o_pc,
    output word_t o_pc_plus_one
);

    word_t pc;

    assign o_pc_plus_one = pc + 16'd1;

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            pc <= `LC4_RESET_PC;
        end else if (i_redirect) begin
            // taken branch wins over a load stall
            pc <= i_target;
        end else if (!i_hold) begin
            pc <= o_pc_plus_one;
        end
    end

    assign o_pc = pc;

endmodule

`default_nettype wire

//--- rtl/lc4_pkg.sv
`default_nettype none

package lc4_pkg;

    // data, address and instruction words
    typedef logic [15:0] word_t;

    // register number
    typedef logic [2:0] reg_sel_t;

    // condition bits {n, z, p}, one-hot for any value
    typedef logic [2:0] nzp_t;

    // stall code presented with each commit
    typedef logic [1:0] stall_t;

endpackage

`default_nettype wire

//--- rtl/lc4_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module lc4_regfile import lc4_pkg::*; (
    input  logic     gwe,
    input  logic     i_reset,
    input  reg_sel_t i_rs_sel,
    input  reg_sel_t i_rt_sel,
    input  reg_sel_t i_rd_sel,
    input  logic     i_rd_we,
    input  word_t    i_wdata,
    output word_t    o_rs_data,
    output word_t    o_rt_data
);

    word_t regs [8];

    always_ff @(posedge gwe) begin
        if (i_reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (i_rd_we) begin
            regs[i_rd_sel] <= i_wdata;
        end
    end

    // write-through, so decode sees the value writeback commits this cycle
    assign o_rs_data = (i_rd_we && (i_rd_sel == i_rs_sel)) ? i_wdata : regs[i_rs_sel];
    assign o_rt_data = (i_rd_we && (i_rd_sel == i_rt_sel)) ? i_wdata : regs[i_rt_sel];

endmodule

`default_nettype wire

//--- run_sim.sh
#!/usr/bin/env bash
# builds the LC4 pipeline testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert -Wno-fatal \
    -f lc4_core.f \
    --top-module lc4_core_tb \
    -Mdir obj_dir -o Vlc4_core_tb \
    && ./obj_dir/Vlc4_core_tb > "$LOG" 2>&1 \
    || { cat "$LOG" 2>/dev/null; echo "simulation build or run failed"; exit 1; }

cat "$LOG"

grep -qx "test passed" "$LOG" \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }

//--- sim/lc4_core_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_core_config.svh"

module lc4_core_sva import lc4_pkg::*; (
    input logic   gwe,
    input logic   i_reset,
    input stall_t o_test_stall,
    input logic   o_test_regfile_we,
    input logic   o_test_nzp_we,
    input logic   o_test_dmem_we,
    input logic   o_dmem_we,
    input word_t  i_m_insn,
    input word_t  o_cur_pc
);

    // a bubble never writes anything
    a_bubble_no_write: assert property (@(posedge gwe) disable iff (i_reset)
        (o_test_stall != 2'd0) |-> !(o_test_regfile_we || o_test_nzp_we || o_test_dmem_we))
        else $error("commit with nonzero stall code has a write enable set");

    // the write strobe has to come from a STR word in the memory stage
    a_dmem_we_store: assert property (@(posedge gwe) disable iff (i_reset)
        o_dmem_we |-> (i_m_insn[15:12] == `LC4_OP_STR))
        else $error("data memory write without a store in the memory stage");

    a_pc_known: assert property (@(posedge gwe) disable iff (i_reset)
        !$isunknown(o_cur_pc))
        else $error("fetch pc is unknown after reset");

endmodule

bind lc4_core lc4_core_sva u_sva (
    .gwe(gwe), .i_reset(i_reset), .o_test_stall(o_test_stall),
    .o_test_regfile_we(o_test_regfile_we), .o_test_nzp_we(o_test_nzp_we),
    .o_test_dmem_we(o_test_dmem_we), .o_dmem_we(o_dmem_we), .i_m_insn(m_insn),
    .o_cur_pc(o_cur_pc)
);

`default_nettype wire

//--- sim/lc4_core_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "lc4_core_config.svh"

module lc4_core_tb import lc4_pkg::*; ();

    localparam int BODY_LEN = 120;
    localparam int PROG_LEN = 128;
    localparam int TIMEOUT  = PROG_LEN * 3 + 50;

    typedef struct packed {
        stall_t   stall;
        word_t    pc;
        word_t    insn;
        logic     rf_we;
        reg_sel_t wsel;
        word_t    rf_data;
        logic     nzp_we;
        nzp_t     nzp;
        logic     dm_we;
        word_t    dm_addr;
        word_t    dm_data;
    } commit_t;

    logic     gwe = 1'b0;
    logic     i_reset;
    word_t    o_cur_pc, i_cur_insn, o_dmem_addr, o_dmem_towrite, i_cur_dmem_data;
    logic     o_dmem_we;
    stall_t   o_test_stall;
    word_t    o_test_pc, o_test_insn, o_test_regfile_data;
    word_t    o_test_dmem_addr, o_test_dmem_data;
    logic     o_test_regfile_we, o_test_nzp_we, o_test_dmem_we;
    reg_sel_t o_test_regfile_wsel;
    nzp_t     o_test_nzp_bits;

    word_t    imem [256];
    word_t    dmem [256];
    word_t    fetch_idx;
    integer   seed;
    int       cycles;
    int       n_checked;
    logic     started;
    commit_t  exp_q [$];
    commit_t  exp_rec;

    // ISA-level model state
    word_t    ref_regs [`LC4_NUM_REGS];
    word_t    ref_mem [256];
    nzp_t     ref_nzp;
    word_t    ref_pc;
    logic     ref_taken;

    lc4_core UUT (
        .gwe(gwe), .i_reset(i_reset), .o_cur_pc(o_cur_pc), .i_cur_insn(i_cur_insn),
        .o_dmem_addr(o_dmem_addr), .o_dmem_we(o_dmem_we), .o_dmem_towrite(o_dmem_towrite),
        .i_cur_dmem_data(i_cur_dmem_data), .o_test_stall(o_test_stall),
        .o_test_pc(o_test_pc), .o_test_insn(o_test_insn),
        .o_test_regfile_we(o_test_regfile_we), .o_test_regfile_wsel(o_test_regfile_wsel),
        .o_test_regfile_data(o_test_regfile_data), .o_test_nzp_we(o_test_nzp_we),
        .o_test_nzp_bits(o_test_nzp_bits), .o_test_dmem_we(o_test_dmem_we),
        .o_test_dmem_addr(o_test_dmem_addr), .o_test_dmem_data(o_test_dmem_data)
    );

    always #10 gwe = ~gwe;

    // instruction memory returns NOPs outside the program
    assign fetch_idx  = o_cur_pc - `LC4_RESET_PC;
    assign i_cur_insn = (fetch_idx < 16'(PROG_LEN)) ? imem[fetch_idx[7:0]] : `LC4_NOP;

    assign i_cur_dmem_data = dmem[o_dmem_addr[7:0]];

    always @(posedge gwe) begin
        if (o_dmem_we) begin
            dmem[o_dmem_addr[7:0]] <= o_dmem_towrite;
        end
    end

    function word_t fill_word(input int addr);
        return word_t'(addr) * 16'h0101 ^ 16'h5a3c;
    endfunction

    function nzp_t nzp_of(input word_t v);
        if (v[15]) return 3'b100;
        if (v == 16'h0000) return 3'b010;
        return 3'b001;
    endfunction

    // decode-stage user of a load destination in the next slot
    function logic needs_load_stall(input word_t insn, input reg_sel_t rd);
        case (insn[15:12])
            `LC4_OP_ADD: return (insn[8:6] == rd) || (!insn[5] && insn[2:0] == rd);
            `LC4_OP_LDR, `LC4_OP_STR: return insn[8:6] == rd;
            `LC4_OP_BR: return insn[11:9] != 3'b000;
            default: return 1'b0;
        endcase
    endfunction

    function commit_t bubble(input stall_t code);
        commit_t rec;
        rec       = '0;
        rec.stall = code;
        return rec;
    endfunction

    function commit_t ref_step(input word_t insn);
        commit_t  rec;
        word_t    a;
        word_t    res;
        logic     wr;
        reg_sel_t rd;
        reg_sel_t rs;
        rd        = insn[11:9];
        rs        = insn[8:6];
        rec       = '0;
        rec.pc    = ref_pc;
        rec.insn  = insn;
        wr        = 1'b0;
        res       = '0;
        ref_taken = 1'b0;
        case (insn[15:12])
            `LC4_OP_ADD: begin
                res = insn[5] ? ref_regs[rs] + {{11{insn[4]}}, insn[4:0]}
                              : ref_regs[rs] + ref_regs[insn[2:0]];
                wr  = 1'b1;
            end
            `LC4_OP_CONST: begin
                res = {{7{insn[8]}}, insn[8:0]};
                wr  = 1'b1;
            end
            `LC4_OP_LDR: begin
                a           = ref_regs[rs] + {{10{insn[5]}}, insn[5:0]};
                res         = ref_mem[a[7:0]];
                rec.dm_addr = a;
                rec.dm_data = res;
                wr          = 1'b1;
            end
            `LC4_OP_STR: begin
                a               = ref_regs[rs] + {{10{insn[5]}}, insn[5:0]};
                rec.dm_we       = 1'b1;
                rec.dm_addr     = a;
                rec.dm_data     = ref_regs[rd];
                ref_mem[a[7:0]] = ref_regs[rd];
            end
            default: begin
                ref_taken = (insn[11:9] & ref_nzp) != 3'b000;
            end
        endcase
        if (wr) begin
            rec.rf_we    = 1'b1;
            rec.wsel     = rd;
            rec.rf_data  = res;
            rec.nzp_we   = 1'b1;
            rec.nzp      = nzp_of(res);
            ref_regs[rd] = res;
            ref_nzp      = rec.nzp;
        end
        ref_pc = ref_taken ? ref_pc + 16'd1 + {{7{insn[8]}}, insn[8:0]} : ref_pc + 16'd1;
        return rec;
    endfunction

    // random body of forward branches, ALU ops and memory ops followed by NOPs
    task gen_program();
        logic [31:0] rnd;
        int          n;
        n = 0;
        while (n < BODY_LEN) begin
            rnd = $random(seed);
            case (rnd[18:16])
                3'd0: imem[n] = {`LC4_OP_BR, rnd[14:12], 6'b000000, rnd[2:0]};
                3'd1: imem[n] = {`LC4_OP_ADD, rnd[11:9], rnd[8:6], 3'b000, rnd[2:0]};
                3'd2: imem[n] = {`LC4_OP_ADD, rnd[11:9], rnd[8:6], 1'b1, rnd[4:0]};
                3'd3: imem[n] = {`LC4_OP_CONST, rnd[11:9], rnd[8:0]};
                3'd4, 3'd5, 3'd6: begin
                    // set up a base register first on about half of them
                    if (rnd[20] && n < BODY_LEN - 1) begin
                        imem[n] = {`LC4_OP_CONST, rnd[8:6], 1'b0, rnd[31:24]};
                        n++;
                    end
                    imem[n] = {(rnd[18:16] == 3'd6) ? `LC4_OP_STR : `LC4_OP_LDR,
                               rnd[11:9], rnd[8:6], rnd[5:0]};
                end
                default: imem[n] = `LC4_NOP;
            endcase
            n++;
        end
    endtask

    task build_expected();
        word_t    insn;
        logic     prev_load;
        reg_sel_t prev_rd;
        ref_pc    = `LC4_RESET_PC;
        ref_nzp   = 3'b010;
        prev_load = 1'b0;
        prev_rd   = '0;
        for (int i = 0; i < `LC4_NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        while (ref_pc - `LC4_RESET_PC < 16'(PROG_LEN)) begin
            insn = imem[8'(ref_pc - `LC4_RESET_PC)];
            if (prev_load && needs_load_stall(insn, prev_rd)) begin
                exp_q.push_back(bubble(`LC4_STALL_LOAD));
            end
            exp_q.push_back(ref_step(insn));
            prev_load = (insn[15:12] == `LC4_OP_LDR);
            prev_rd   = insn[11:9];
            if (ref_taken) begin
                exp_q.push_back(bubble(`LC4_STALL_FLUSH));
                exp_q.push_back(bubble(`LC4_STALL_FLUSH));
            end
        end
    endtask

    task fail_run();
        $display("test failed");
        $fatal(1);
    endtask

    task check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            $display("FAILED commit %0d %s: expected %h, actual %h", n_checked, name, exp, act);
            fail_run();
        end
    endtask

    task check_sel(input string name, input reg_sel_t exp, input reg_sel_t act);
        if (act !== exp) begin
            $display("FAILED commit %0d %s: expected %0d, actual %0d", n_checked, name, exp, act);
            fail_run();
        end
    endtask

    task check_nzp(input string name, input nzp_t exp, input nzp_t act);
        if (act !== exp) begin
            $display("FAILED commit %0d %s: expected %b, actual %b", n_checked, name, exp, act);
            fail_run();
        end
    endtask

    task check_stall(input string name, input stall_t exp, input stall_t act);
        if (act !== exp) begin
            $display("FAILED commit %0d %s: expected %0d, actual %0d", n_checked, name, exp, act);
            fail_run();
        end
    endtask

    task check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAILED commit %0d %s: expected %b, actual %b", n_checked, name, exp, act);
            fail_run();
        end
    endtask

    task compare_commit(input commit_t rec);
        check_stall("stall", rec.stall, o_test_stall);
        check_bit("regfile_we", rec.rf_we, o_test_regfile_we);
        check_bit("nzp_we", rec.nzp_we, o_test_nzp_we);
        check_bit("dmem_we", rec.dm_we, o_test_dmem_we);
        if (rec.stall == `LC4_STALL_NONE) begin
            check_word("pc", rec.pc, o_test_pc);
            check_word("insn", rec.insn, o_test_insn);
            if (rec.rf_we) begin
                check_sel("regfile_wsel", rec.wsel, o_test_regfile_wsel);
                check_word("regfile_data", rec.rf_data, o_test_regfile_data);
            end
            if (rec.nzp_we) begin
                check_nzp("nzp_bits", rec.nzp, o_test_nzp_bits);
            end
            check_word("dmem_addr", rec.dm_addr, o_test_dmem_addr);
            check_word("dmem_data", rec.dm_data, o_test_dmem_data);
        end
    endtask

    initial begin
        i_reset   = 1'b1;
        seed      = 32'h2689;
        started   = 1'b0;
        cycles    = 0;
        n_checked = 0;
        for (int i = 0; i < 256; i++) begin
            imem[i]    = `LC4_NOP;
            dmem[i]   <= fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        gen_program();
        build_expected();
        repeat (16) @(negedge gwe);
        i_reset <= 1'b0;
    end

    // commit outputs change on the rising edge and are settled by the falling edge
    always @(negedge gwe) begin
        if (!i_reset) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                $display("program did not finish");
                fail_run();
            end else if (!started && o_test_stall == `LC4_STALL_FLUSH) begin
                check_bit("reset regfile_we", 1'b0, o_test_regfile_we);
                check_bit("reset nzp_we", 1'b0, o_test_nzp_we);
                check_bit("reset dmem_we", 1'b0, o_test_dmem_we);
            end else begin
                started = 1'b1;
                exp_rec = exp_q.pop_front();
                compare_commit(exp_rec);
                n_checked++;
                if (exp_q.size() == 0) begin
                    $display("test passed");
                    $finish;
                end
            end
        end
    end

endmodule

`default_nettype wire
